// File: vlog.f
+incdir+verilog
verilog/dirccTypesPkg.sv
verilog/packetSender.sv
verilog/packetReceiver.sv
verilog/lamportClock.sv
verilog/dirccNode.sv
sim/dirccNodeTb.sv

// File: run.sh
#!/bin/sh
# Build and run the dirccNode testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module dirccNodeTb \
  -o dirccNodeSim

# The simulator exits non-zero on a failed check, the log search decides the result
./obj_dir/dirccNodeSim 2>&1 | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// File: sim/dirccNodeTb.sv
`timescale 1ns/1ns
`include "dircc_defs.svh"

module dirccNodeTb;

  localparam int ClkPeriod      = 10;
  localparam int RandomSends    = 5;
  localparam int TxPackets      = RandomSends + 2;  // Plus full-rate and combined sends
  localparam int RxBeats        = 4 * 8 + (3 + 8) + (5 + 8) + 8;
  localparam int TotalBeats     = 8 * TxPackets + RxBeats;
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic clk;
  logic reset_n;
  logic txReady;
  logic [`DIRCC_BEAT_WIDTH-1:0]    rxData;
  logic [`DIRCC_EMPTY_WIDTH-1:0]   rxEmpty;
  logic rxStartOfPacket;
  logic rxEndOfPacket;
  logic rxValid;
  logic sendStart;
  dirccTypesPkg::address_t         sendDestAddr;
  logic [`DIRCC_PAYLOAD_WIDTH-1:0] sendPayload;
  dirccTypesPkg::address_t         nodeAddr;
  logic [`DIRCC_BEAT_WIDTH-1:0]    txData;
  logic [`DIRCC_EMPTY_WIDTH-1:0]   txEmpty;
  logic txStartOfPacket;
  logic txEndOfPacket;
  logic txValid;
  logic sending;
  logic recvValid;
  logic recvError;
  dirccTypesPkg::address_t         recvSrcAddr;
  dirccTypesPkg::address_t         recvDestAddr;
  logic [`DIRCC_LAMPORT_WIDTH-1:0] recvLamport;
  logic [`DIRCC_PAYLOAD_WIDTH-1:0] recvPayload;
  logic [`DIRCC_LAMPORT_WIDTH-1:0] lamportTime;

  logic [31:0] lfsrState = 32'h8420;
  logic        readyRandom;
  logic        rxDoneMark;  // Beat should complete a good packet
  logic        rxErrMark;   // Beat should raise a framing error

  // Reference model state
  dirccTypesPkg::packet_t expPkt [0:31];
  dirccTypesPkg::packet_t curRxPkt;
  dirccTypesPkg::packet_t doneRxPkt;
  logic [4:0]  txPackets;
  logic [7:0]  beatCount;
  logic [4:0]  pktIdx;
  logic [2:0]  beatIdx;
  logic [31:0] expWord;
  logic        txPending;
  logic        expRecvValid;
  logic        expRecvError;
  logic [`DIRCC_LAMPORT_WIDTH-1:0] modelTime;
  logic [`DIRCC_LAMPORT_WIDTH-1:0] modelStamp;

  dirccNode dirccNode_inst (.*);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [95:0] randomBits(input int count);
    logic [95:0] value;
    int          i;
    value = '0;
    for (i = 0; i < count; i++) begin
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ LfsrTaps) : (lfsrState >> 1);
      value = {value[94:0], lfsrState[0]};
    end
    return value;
  endfunction

  // Wire layout of one beat
  function automatic logic [31:0] beatWord(input dirccTypesPkg::packet_t p,
                                           input logic [2:0] idx);
    case (idx)
      3'd0:    return p.destAddr.hwAddr;
      3'd1:    return {p.destAddr.swAddr, p.destAddr.port, p.destAddr.flag, 8'h00};
      3'd2:    return p.srcAddr.hwAddr;
      3'd3:    return {p.srcAddr.swAddr, p.srcAddr.port, p.srcAddr.flag, 8'h00};
      3'd4:    return p.lamport;
      3'd5:    return p.payload[31:0];
      3'd6:    return p.payload[63:32];
      default: return p.payload[95:64];
    endcase
  endfunction

  function automatic logic [31:0] nextTime(input logic [31:0] t, input logic tickIn,
                                           input logic mergeIn, input logic [31:0] mTime);
    logic [31:0] maxTime;
    maxTime = (mTime > t) ? mTime : t;
    if (mergeIn) begin
      return maxTime + (tickIn ? 32'd2 : 32'd1);
    end
    return t + (tickIn ? 32'd1 : 32'd0);
  endfunction

  function automatic dirccTypesPkg::packet_t randomPacket();
    dirccTypesPkg::packet_t p;
    logic [95:0] rnd;
    rnd = randomBits(56);
    p.destAddr = rnd[55:0];
    rnd = randomBits(56);
    p.srcAddr = rnd[55:0];
    rnd = randomBits(12);   // Small stamps so merges go both ways
    p.lamport = {20'h0, rnd[11:0]};
    p.payload = randomBits(96);
    return p;
  endfunction

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1, "Check failed");
  endtask

  task automatic loadSendFields();
    logic [95:0] rnd;
    rnd = randomBits(56);
    sendDestAddr = rnd[55:0];
    sendPayload  = randomBits(96);
    sendStart    = 1'b1;
  endtask

  task automatic waitIdle();
    @(negedge clk);
    while (sending) @(negedge clk);
  endtask

  task automatic startSend();
    waitIdle();
    loadSendFields();
    @(negedge clk);
    sendStart = 1'b0;
  endtask

  task automatic driveRxBeat(input logic [31:0] data, input logic sop, input logic eop,
                             input logic done, input logic err);
    logic [95:0] gap;
    @(negedge clk);
    gap = randomBits(2);
    while (gap[1:0] == 2'b00) begin
      rxValid    = 1'b0;
      rxDoneMark = 1'b0;
      rxErrMark  = 1'b0;
      @(negedge clk);
      gap = randomBits(2);
    end
    rxData          = data;
    rxStartOfPacket = sop;
    rxEndOfPacket   = eop;
    rxDoneMark      = done;
    rxErrMark       = err;
    rxValid         = 1'b1;
  endtask

  // eopAt past the last beat leaves endofpacket off
  task automatic driveRxPacket(input dirccTypesPkg::packet_t p, input int numBeats,
                               input int eopAt, input logic firstErr);
    int i;
    curRxPkt = p;
    for (i = 0; i < numBeats; i++) begin
      driveRxBeat(beatWord(p, i[2:0]), i == 0, i == eopAt, (i == 7) && (eopAt == 7),
                  ((i == 0) && firstErr) || ((i == eopAt) && (eopAt != 7)));
    end
  endtask

  // Idle the rx stream and optionally send in the recvValid cycle
  task automatic endRx(input logic withSend);
    @(negedge clk);
    rxValid    = 1'b0;
    rxDoneMark = 1'b0;
    rxErrMark  = 1'b0;
    if (withSend) begin
      loadSendFields();
      @(negedge clk);
      sendStart = 1'b0;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Reference model and stream monitor
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign pktIdx     = beatCount[7:3];
  assign beatIdx    = beatCount[2:0];
  assign expWord    = beatWord(expPkt[pktIdx], beatIdx);
  assign txPending  = ({txPackets, 3'b000} != (beatCount + 8'(txValid)));  // Beats not launched
  assign modelStamp = nextTime(modelTime, sendStart, expRecvValid, doneRxPkt.lamport);

  always @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      modelTime    <= '0;
      txPackets    <= '0;
      beatCount    <= '0;
      expRecvValid <= 1'b0;
      expRecvError <= 1'b0;
      doneRxPkt    <= '0;
    end else begin
      modelTime <= modelStamp;
      if (sendStart) begin
        expPkt[txPackets] <= {sendDestAddr, nodeAddr, modelStamp, sendPayload};
        txPackets         <= txPackets + 5'd1;
      end
      if (txValid) begin
        beatCount <= beatCount + 8'd1;
      end
      expRecvValid <= rxValid && rxDoneMark;
      expRecvError <= rxValid && rxErrMark;
      if (rxValid && rxDoneMark) begin
        doneRxPkt <= curRxPkt;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  txDataCheck: assert property (@(posedge clk) disable iff (!reset_n)
    txValid |-> (txData == expWord))
    else failRun($sformatf("ERR txData got %h exp %h", $sampled(txData), $sampled(expWord)));

  txSopCheck: assert property (@(posedge clk) disable iff (!reset_n)
    txValid |-> (txStartOfPacket == (beatIdx == 3'd0)))
    else failRun($sformatf("ERR txStartOfPacket got %h at beat %h",
                           $sampled(txStartOfPacket), $sampled(beatIdx)));

  txEopCheck: assert property (@(posedge clk) disable iff (!reset_n)
    txValid |-> (txEndOfPacket == (beatIdx == 3'd7)))
    else failRun($sformatf("ERR txEndOfPacket got %h at beat %h",
                           $sampled(txEndOfPacket), $sampled(beatIdx)));

  txEmptyCheck: assert property (@(posedge clk) disable iff (!reset_n)
    txValid |-> (txEmpty == '0))
    else failRun($sformatf("ERR txEmpty got %h exp 0", $sampled(txEmpty)));

  // Ready latency of one with no skipped or stalled beat
  txValidCheck: assert property (@(posedge clk) disable iff (!reset_n)
    txValid == $past(txPending && txReady))
    else failRun($sformatf("ERR txValid got %h exp %h", $sampled(txValid),
                           !$sampled(txValid)));

  sendingCheck: assert property (@(posedge clk) disable iff (!reset_n)
    sending == (txPending || txValid))
    else failRun($sformatf("ERR sending got %h exp %h", $sampled(sending),
                           $sampled(txPending || txValid)));

  recvValidCheck: assert property (@(posedge clk) disable iff (!reset_n)
    recvValid == expRecvValid)
    else failRun($sformatf("ERR recvValid got %h exp %h", $sampled(recvValid),
                           $sampled(expRecvValid)));

  recvErrorCheck: assert property (@(posedge clk) disable iff (!reset_n)
    recvError == expRecvError)
    else failRun($sformatf("ERR recvError got %h exp %h", $sampled(recvError),
                           $sampled(expRecvError)));

  recvAddrCheck: assert property (@(posedge clk) disable iff (!reset_n)
    recvValid |-> ({recvDestAddr, recvSrcAddr} == {doneRxPkt.destAddr, doneRxPkt.srcAddr}))
    else failRun($sformatf("ERR recvDestAddr/recvSrcAddr got %h exp %h",
                           $sampled({recvDestAddr, recvSrcAddr}),
                           $sampled({doneRxPkt.destAddr, doneRxPkt.srcAddr})));

  recvDataCheck: assert property (@(posedge clk) disable iff (!reset_n)
    recvValid |-> ({recvLamport, recvPayload} == {doneRxPkt.lamport, doneRxPkt.payload}))
    else failRun($sformatf("ERR recvLamport/recvPayload got %h exp %h",
                           $sampled({recvLamport, recvPayload}),
                           $sampled({doneRxPkt.lamport, doneRxPkt.payload})));

  lamportCheck: assert property (@(posedge clk) disable iff (!reset_n)
    lamportTime == modelTime)
    else failRun($sformatf("ERR lamportTime got %h exp %h", $sampled(lamportTime),
                           $sampled(modelTime)));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Clock, ready pattern, watchdog
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    logic [95:0] readyBits;
    txReady = 1'b0;
    forever begin
      @(negedge clk);
      readyBits = randomBits(1);
      txReady   = !readyRandom || readyBits[0];
    end
  end

  initial begin
    #(40 * TotalBeats * ClkPeriod);
    $display("Watchdog expired before all packets were checked");
    $display("STATUS: FAIL");
    $fatal(1, "Timeout");
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    logic [95:0] rnd;
    reset_n         = 1'b0;
    readyRandom     = 1'b0;
    rxData          = '0;
    rxEmpty         = '0;
    rxStartOfPacket = 1'b0;
    rxEndOfPacket   = 1'b0;
    rxValid         = 1'b0;
    rxDoneMark      = 1'b0;
    rxErrMark       = 1'b0;
    sendStart       = 1'b0;
    sendDestAddr    = '0;
    sendPayload     = '0;
    curRxPkt        = '0;
    rnd             = randomBits(56);
    nodeAddr        = rnd[55:0];
    repeat (8) @(negedge clk);
    reset_n = 1'b1;

    startSend();  // Full rate with beats on consecutive cycles
    waitIdle();
    readyRandom = 1'b1;
    repeat (RandomSends) startSend();
    waitIdle();

    repeat (4) begin
      driveRxPacket(randomPacket(), 8, 7, 1'b0);
      endRx(1'b0);
    end

    driveRxPacket(randomPacket(), 3, 8, 1'b0);  // Cut short by a new start
    driveRxPacket(randomPacket(), 8, 7, 1'b1);
    endRx(1'b0);
    driveRxPacket(randomPacket(), 5, 4, 1'b0);  // Early endofpacket
    endRx(1'b0);
    driveRxPacket(randomPacket(), 8, 7, 1'b0);
    endRx(1'b0);

    // Send in the same cycle the receiver completes
    driveRxPacket(randomPacket(), 8, 7, 1'b0);
    endRx(1'b1);
    waitIdle();
    repeat (4) @(negedge clk);

    if (beatCount != {txPackets, 3'b000}) begin
      failRun("Transmit monitor did not see every beat of the sent packets");
    end else begin
      $display("STATUS: PASS");
      $finish;
    end
  end

endmodule

// File: verilog/dirccNode.sv
`timescale 1ns/1ns
`include "dircc_defs.svh"

module dirccNode (
  input  logic                              clk,
  input  logic                              reset_n,
  // Transmit stream
  output logic [`DIRCC_BEAT_WIDTH-1:0]      txData,
  output logic [`DIRCC_EMPTY_WIDTH-1:0]     txEmpty,
  output logic                              txStartOfPacket,
  output logic                              txEndOfPacket,
  output logic                              txValid,
  input  logic                              txReady,
  // Receive stream
  input  logic [`DIRCC_BEAT_WIDTH-1:0]      rxData,
  input  logic [`DIRCC_EMPTY_WIDTH-1:0]     rxEmpty,
  input  logic                              rxStartOfPacket,
  input  logic                              rxEndOfPacket,
  input  logic                              rxValid,
  // Host side
  input  logic                              sendStart,
  input  dirccTypesPkg::address_t           sendDestAddr,
  input  logic [`DIRCC_PAYLOAD_WIDTH-1:0]   sendPayload,
  input  dirccTypesPkg::address_t           nodeAddr,
  output logic                              sending,
  output logic                              recvValid,
  output dirccTypesPkg::address_t           recvSrcAddr,
  output dirccTypesPkg::address_t           recvDestAddr,
  output logic [`DIRCC_LAMPORT_WIDTH-1:0]   recvLamport,
  output logic [`DIRCC_PAYLOAD_WIDTH-1:0]   recvPayload,
  output logic                              recvError,
  output logic [`DIRCC_LAMPORT_WIDTH-1:0]   lamportTime
);

  logic [`DIRCC_LAMPORT_WIDTH-1:0] stamp;  // Time after this cycle's events

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Datapath
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  packetSender packetSender_inst (
    .clk             (clk),
    .reset_n         (reset_n),
    .sendStart       (sendStart),
    .sendDestAddr    (sendDestAddr),
    .nodeAddr        (nodeAddr),
    .sendPayload     (sendPayload),
    .stamp           (stamp),
    .txReady         (txReady),
    .txData          (txData),
    .txEmpty         (txEmpty),
    .txStartOfPacket (txStartOfPacket),
    .txEndOfPacket   (txEndOfPacket),
    .txValid         (txValid),
    .sending         (sending)
  );

  packetReceiver packetReceiver_inst (
    .clk             (clk),
    .reset_n         (reset_n),
    .rxData          (rxData),
    .rxEmpty         (rxEmpty),
    .rxStartOfPacket (rxStartOfPacket),
    .rxEndOfPacket   (rxEndOfPacket),
    .rxValid         (rxValid),
    .recvValid       (recvValid),
    .recvSrcAddr     (recvSrcAddr),
    .recvDestAddr    (recvDestAddr),
    .recvLamport     (recvLamport),
    .recvPayload     (recvPayload),
    .recvError       (recvError)
  );

  // Ticks on send, merges on each parsed packet
  lamportClock lamportClock_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .tick        (sendStart),
    .merge       (recvValid),
    .mergeTime   (recvLamport),
    .stamp       (stamp),
    .lamportTime (lamportTime)
  );

endmodule

// File: verilog/lamportClock.sv
`timescale 1ns/1ns
`include "dircc_defs.svh"

module lamportClock (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              tick,
  input  logic                              merge,
  input  logic [`DIRCC_LAMPORT_WIDTH-1:0]   mergeTime,
  output logic [`DIRCC_LAMPORT_WIDTH-1:0]   stamp,
  output logic [`DIRCC_LAMPORT_WIDTH-1:0]   lamportTime
);

  localparam int TimeWidth = `DIRCC_LAMPORT_WIDTH;

  logic [TimeWidth-1:0] baseTime;
  logic [1:0]           increment;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Next time
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    if (merge && (mergeTime > lamportTime)) begin
      baseTime = mergeTime;  // Catch up with the sender
    end else begin
      baseTime = lamportTime;
    end
    increment = {1'b0, tick} + {1'b0, merge};  // One event each
    stamp     = baseTime + TimeWidth'(increment);
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      lamportTime <= '0;
    end else begin
      lamportTime <= stamp;
    end
  end

  // Logical time is monotonic
  timeNeverDecreases: assert property (
    @(posedge clk) disable iff (!reset_n)
    $past(lamportTime) <= lamportTime
  );

endmodule

// File: verilog/packetReceiver.sv
`timescale 1ns/1ns
`include "dircc_defs.svh"

module packetReceiver (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic [`DIRCC_BEAT_WIDTH-1:0]      rxData,
  input  logic [`DIRCC_EMPTY_WIDTH-1:0]     rxEmpty,
  input  logic                              rxStartOfPacket,
  input  logic                              rxEndOfPacket,
  input  logic                              rxValid,
  output logic                              recvValid,
  output dirccTypesPkg::address_t           recvSrcAddr,
  output dirccTypesPkg::address_t           recvDestAddr,
  output logic [`DIRCC_LAMPORT_WIDTH-1:0]   recvLamport,
  output logic [`DIRCC_PAYLOAD_WIDTH-1:0]   recvPayload,
  output logic                              recvError
);

  localparam int BeatWidth = `DIRCC_BEAT_WIDTH;
  localparam int SymWidth  = `DIRCC_BITS_PER_SYMBOL;

  dirccTypesPkg::packetState_t expectState;  // Next beat we should see
  dirccTypesPkg::packetState_t storeState;
  logic firstBeat;
  logic lastBeat;
  logic framingOk;
  logic restart;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Framing check
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    firstBeat = (expectState == dirccTypesPkg::DEST_ADDR0);
    lastBeat  = (expectState == dirccTypesPkg::DATA2);
    framingOk = (rxEmpty == '0) && (rxStartOfPacket == firstBeat)
                && (rxEndOfPacket == lastBeat);
    // Stray startofpacket opens a new packet
    restart   = rxStartOfPacket && !firstBeat && !rxEndOfPacket && (rxEmpty == '0);
    storeState = restart ? dirccTypesPkg::DEST_ADDR0 : expectState;
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      expectState <= dirccTypesPkg::DEST_ADDR0;
      recvValid   <= 1'b0;
      recvError   <= 1'b0;
    end else begin
      recvValid <= rxValid && framingOk && lastBeat;
      recvError <= rxValid && !framingOk;
      if (rxValid) begin
        if (restart) begin
          expectState <= dirccTypesPkg::DEST_ADDR1;
        end else if (!framingOk || lastBeat) begin
          expectState <= dirccTypesPkg::DEST_ADDR0;
        end else begin
          expectState <= dirccTypesPkg::packetState_t'(expectState + 4'd1);
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Field assembly
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk) begin
    if (rxValid && (framingOk || restart)) begin
      case (storeState)
        dirccTypesPkg::DEST_ADDR0: recvDestAddr.hwAddr <= rxData;
        dirccTypesPkg::DEST_ADDR1: begin
          {recvDestAddr.swAddr, recvDestAddr.port, recvDestAddr.flag}
            <= rxData[BeatWidth-1:SymWidth];  // Low byte is padding
        end
        dirccTypesPkg::SRC_ADDR0:  recvSrcAddr.hwAddr <= rxData;
        dirccTypesPkg::SRC_ADDR1: begin
          {recvSrcAddr.swAddr, recvSrcAddr.port, recvSrcAddr.flag}
            <= rxData[BeatWidth-1:SymWidth];
        end
        dirccTypesPkg::LAMPORT:    recvLamport <= rxData;
        dirccTypesPkg::DATA0:      recvPayload[0 +: BeatWidth] <= rxData;
        dirccTypesPkg::DATA1:      recvPayload[BeatWidth +: BeatWidth] <= rxData;
        dirccTypesPkg::DATA2:      recvPayload[2*BeatWidth +: BeatWidth] <= rxData;
        default: ;
      endcase
    end
  end

  // A completed packet and a framing error are exclusive outcomes
  validErrorExclusive: assert property (
    @(posedge clk) disable iff (!reset_n)
    !(recvValid && recvError)
  );

endmodule

// File: verilog/packetSender.sv
`timescale 1ns/1ns
`include "dircc_defs.svh"

module packetSender (
  input  logic                              clk,
  input  logic                              reset_n,
  input  logic                              sendStart,
  input  dirccTypesPkg::address_t           sendDestAddr,
  input  dirccTypesPkg::address_t           nodeAddr,
  input  logic [`DIRCC_PAYLOAD_WIDTH-1:0]   sendPayload,
  input  logic [`DIRCC_LAMPORT_WIDTH-1:0]   stamp,
  input  logic                              txReady,
  output logic [`DIRCC_BEAT_WIDTH-1:0]      txData,
  output logic [`DIRCC_EMPTY_WIDTH-1:0]     txEmpty,
  output logic                              txStartOfPacket,
  output logic                              txEndOfPacket,
  output logic                              txValid,
  output logic                              sending
);

  localparam int BeatWidth = `DIRCC_BEAT_WIDTH;

  dirccTypesPkg::packet_t      packetReg;
  dirccTypesPkg::packetState_t packetState;
  logic [BeatWidth-1:0]        beatData;
  logic                        beatAdvance;

  // Busy until the last beat has left the output register
  assign sending = (packetState != dirccTypesPkg::IDLE) || txValid;

  assign beatAdvance = (packetState != dirccTypesPkg::IDLE) && txReady;

  // Fixed-length packets leave every beat full
  assign txEmpty = '0;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat mux
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    case (packetState)
      dirccTypesPkg::DEST_ADDR0: beatData = packetReg.destAddr.hwAddr;
      dirccTypesPkg::DEST_ADDR1: begin
        beatData = {packetReg.destAddr.swAddr, packetReg.destAddr.port,
                    packetReg.destAddr.flag, {`DIRCC_BITS_PER_SYMBOL{1'b0}}};
      end
      dirccTypesPkg::SRC_ADDR0:  beatData = packetReg.srcAddr.hwAddr;
      dirccTypesPkg::SRC_ADDR1: begin
        beatData = {packetReg.srcAddr.swAddr, packetReg.srcAddr.port,
                    packetReg.srcAddr.flag, {`DIRCC_BITS_PER_SYMBOL{1'b0}}};
      end
      dirccTypesPkg::LAMPORT:    beatData = packetReg.lamport;
      dirccTypesPkg::DATA0:      beatData = packetReg.payload[0 +: BeatWidth];
      dirccTypesPkg::DATA1:      beatData = packetReg.payload[BeatWidth +: BeatWidth];
      dirccTypesPkg::DATA2:      beatData = packetReg.payload[2*BeatWidth +: BeatWidth];
      default:                   beatData = '0;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat sequencer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      packetState     <= dirccTypesPkg::IDLE;
      txValid         <= 1'b0;
      txStartOfPacket <= 1'b0;
      txEndOfPacket   <= 1'b0;
    end else if (packetState == dirccTypesPkg::IDLE) begin
      txValid <= 1'b0;
      if (sendStart) begin
        packetState <= dirccTypesPkg::DEST_ADDR0;
      end
    end else if (txReady) begin
      txValid         <= 1'b1;  // Ready latency of one
      txStartOfPacket <= (packetState == dirccTypesPkg::DEST_ADDR0);
      txEndOfPacket   <= (packetState == dirccTypesPkg::DATA2);
      if (packetState == dirccTypesPkg::DATA2) begin
        packetState <= dirccTypesPkg::IDLE;
      end else begin
        packetState <= dirccTypesPkg::packetState_t'(packetState + 4'd1);
      end
    end else begin
      txValid <= 1'b0;  // Hold the beat index
    end
  end

  // Packet and beat data
  always_ff @(posedge clk) begin
    if ((packetState == dirccTypesPkg::IDLE) && sendStart) begin
      packetReg.destAddr <= sendDestAddr;
      packetReg.srcAddr  <= nodeAddr;
      packetReg.lamport  <= stamp;
      packetReg.payload  <= sendPayload;
    end
    if (beatAdvance) begin
      txData <= beatData;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Only one packet in flight
  noSendWhileBusy: assert property (
    @(posedge clk) disable iff (!reset_n)
    sendStart |-> !sending
  );

  // startofpacket only on the beat that moved the sequencer to DEST_ADDR1
  sopOnFirstBeat: assert property (
    @(posedge clk) disable iff (!reset_n)
    txValid |-> (txStartOfPacket == (packetState == dirccTypesPkg::DEST_ADDR1))
  );

endmodule

// File: verilog/dirccTypesPkg.sv
`include "dircc_defs.svh"

package dirccTypesPkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Node address, sent as two beats
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  typedef struct packed {
    logic [`DIRCC_HW_ADDR_WIDTH-1:0] hwAddr;
    logic [`DIRCC_SW_ADDR_WIDTH-1:0] swAddr;
    logic [`DIRCC_PORT_WIDTH-1:0]    port;
    logic [`DIRCC_FLAG_WIDTH-1:0]    flag;
  } address_t;

  // Whole message as held by the sender
  typedef struct packed {
    address_t                        destAddr;
    address_t                        srcAddr;
    logic [`DIRCC_LAMPORT_WIDTH-1:0] lamport;
    logic [`DIRCC_PAYLOAD_WIDTH-1:0] payload;
  } packet_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Beat index
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Values run in wire order so the next beat is state + 1
  typedef enum logic [3:0] {
    IDLE       = 4'd0,
    DEST_ADDR0 = 4'd1,
    DEST_ADDR1 = 4'd2,
    SRC_ADDR0  = 4'd3,
    SRC_ADDR1  = 4'd4,
    LAMPORT    = 4'd5,
    DATA0      = 4'd6,
    DATA1      = 4'd7,
    DATA2      = 4'd8   // Last beat, carries endofpacket
  } packetState_t;

endpackage

// File: verilog/dircc_defs.svh
`ifndef DIRCC_DEFS_SVH
`define DIRCC_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Stream geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DIRCC_BITS_PER_SYMBOL   8
`define DIRCC_SYMBOLS_PER_BEAT  4
`define DIRCC_BEAT_WIDTH        (`DIRCC_BITS_PER_SYMBOL * `DIRCC_SYMBOLS_PER_BEAT)
`define DIRCC_EMPTY_WIDTH       2

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Message fields
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define DIRCC_HW_ADDR_WIDTH     32
`define DIRCC_SW_ADDR_WIDTH     8
`define DIRCC_PORT_WIDTH        8
`define DIRCC_FLAG_WIDTH        8
`define DIRCC_LAMPORT_WIDTH     32
`define DIRCC_PAYLOAD_WIDTH     96  // Three beats of data

// Header beats plus data beats
`define DIRCC_BEATS_PER_PACKET  8

`endif
